// File: glb_cfg_settings.svh
`ifndef GLB_CFG_SETTINGS_SVH
`define GLB_CFG_SETTINGS_SVH

// tiles in the chain
`define GLB_NUM_TILES 4

// tile-select field, wide enough for ids past the last tile
`define GLB_TILE_ID_WIDTH 4

// register-select field inside one tile
`define GLB_REG_ADDR_WIDTH 6

// byte offset bits, ignored by decode
`define GLB_BYTE_OFFSET 2

// config data width
`define GLB_DATA_WIDTH 32

// implemented registers per tile
`define GLB_NUM_REGS 16

// full byte address: offset, then register, then tile
`define GLB_CFG_ADDR_WIDTH (`GLB_BYTE_OFFSET + `GLB_REG_ADDR_WIDTH + `GLB_TILE_ID_WIDTH)

`endif

// File: glb_cfg_pkg.sv
`include "glb_cfg_settings.svh"

package glb_cfg_pkg;

    // byte address, lsb first: byte offset, register, tile
    typedef logic [`GLB_CFG_ADDR_WIDTH-1:0] cfg_addr_t;
    typedef logic [`GLB_DATA_WIDTH-1:0]     cfg_data_t;
    typedef logic [`GLB_TILE_ID_WIDTH-1:0]  tile_id_t;
    typedef logic [`GLB_REG_ADDR_WIDTH-1:0] reg_addr_t;

    // host write request, travels west to east
    typedef struct packed {
        logic      wr_en;
        logic      wr_clk_en;
        cfg_addr_t wr_addr;
        cfg_data_t wr_data;
    } cfg_wr_req_t;

    // host read request, travels west to east
    typedef struct packed {
        logic      rd_en;
        logic      rd_clk_en;
        cfg_addr_t rd_addr;
    } cfg_rd_req_t;

    // read response, travels east to west
    typedef struct packed {
        cfg_data_t rd_data;
        logic      rd_data_valid;
    } cfg_rd_rsp_t;

    // local register bus, controller to register file
    typedef struct packed {
        cfg_data_t write_data;
        reg_addr_t address;
        logic      read;
        logic      write;
    } pio_req_t;

    // register file answer, two cycles after a read
    typedef struct packed {
        cfg_data_t read_data;
        logic      ack;
        logic      nack;
    } pio_rsp_t;

endpackage

// File: glb_tile_cfg_ctrl.sv
`timescale 1ns/1ns
`include "glb_cfg_settings.svh"

module glb_tile_cfg_ctrl
    import glb_cfg_pkg::*;
#(
    parameter tile_id_t TILE_ID = '0
) (
    input  logic        clk,
    input  logic        reset,
    // west side, toward the host
    input  cfg_wr_req_t wr_wst,
    input  cfg_rd_req_t rd_wst,
    output cfg_rd_rsp_t rsp_wst,
    // east side, toward the next tile
    output cfg_wr_req_t wr_est,
    output cfg_rd_req_t rd_est,
    input  cfg_rd_rsp_t rsp_est,
    // local register bus
    output pio_req_t    pio_req,
    input  pio_rsp_t    pio_rsp
);

    // field positions inside a byte address
    localparam int REG_LSB  = `GLB_BYTE_OFFSET;
    localparam int TILE_LSB = `GLB_BYTE_OFFSET + `GLB_REG_ADDR_WIDTH;

    tile_id_t  wr_tile;
    tile_id_t  rd_tile;
    logic      wr_match;
    logic      rd_match;
    logic      rd_en_d1;
    logic      rd_en_d2;
    logic      loc_capture;
    logic      loc_valid_q;
    cfg_data_t loc_data_q;
    logic      rsp_valid_q;
    cfg_data_t rsp_data_q;

    // tile select of each incoming request
    assign wr_tile  = wr_wst.wr_addr[TILE_LSB +: `GLB_TILE_ID_WIDTH];
    assign rd_tile  = rd_wst.rd_addr[TILE_LSB +: `GLB_TILE_ID_WIDTH];
    assign wr_match = (wr_tile == TILE_ID);
    assign rd_match = (rd_tile == TILE_ID);

    // pio decode, same cycle as the west inputs
    always_comb begin
        pio_req = '0;
        if (rd_wst.rd_en && rd_match) begin
            pio_req.address = rd_wst.rd_addr[REG_LSB +: `GLB_REG_ADDR_WIDTH];
            pio_req.read    = 1'b1;
        end
        // a matching write takes the bus, the read is lost
        if (wr_wst.wr_en && wr_match) begin
            pio_req.write_data = wr_wst.wr_data;
            pio_req.address    = wr_wst.wr_addr[REG_LSB +: `GLB_REG_ADDR_WIDTH];
            pio_req.read       = 1'b0;
            pio_req.write      = 1'b1;
        end
    end

    // write forwarding east, one hop per cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_est <= '0;
        end else begin
            // enable wave trails the request by one hop
            wr_est.wr_clk_en <= wr_wst.wr_clk_en;
            if (wr_wst.wr_clk_en) begin
                wr_est.wr_en <= wr_wst.wr_en && !wr_match;
                if (wr_wst.wr_en && !wr_match) begin
                    wr_est.wr_addr <= wr_wst.wr_addr;
                    wr_est.wr_data <= wr_wst.wr_data;
                end
            end
        end
    end

    // read forwarding east
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_est <= '0;
        end else begin
            rd_est.rd_clk_en <= rd_wst.rd_clk_en;
            if (rd_wst.rd_clk_en) begin
                rd_est.rd_en <= rd_wst.rd_en && !rd_match;
                if (rd_wst.rd_en && !rd_match) begin
                    rd_est.rd_addr <= rd_wst.rd_addr;
                end
            end
        end
    end

    // read strobe delayed to line up with the register file answer
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_en_d1 <= 1'b0;
            rd_en_d2 <= 1'b0;
        end else begin
            rd_en_d1 <= pio_req.read;
            rd_en_d2 <= rd_en_d1;
        end
    end

    // ack and nack both end the read; nack data is already zero
    assign loc_capture = rd_en_d2 && (pio_rsp.ack || pio_rsp.nack);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            loc_valid_q <= 1'b0;
        end else begin
            loc_valid_q <= loc_capture;
        end
    end

    always_ff @(posedge clk) begin
        if (loc_capture) begin
            loc_data_q <= pio_rsp.read_data;
        end
    end

    // west response, local answer beats the one from the east
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rsp_valid_q <= 1'b0;
        end else if (rd_wst.rd_clk_en) begin
            rsp_valid_q <= loc_valid_q || rsp_est.rd_data_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_wst.rd_clk_en) begin
            rsp_data_q <= loc_valid_q ? loc_data_q : rsp_est.rd_data;
        end
    end

    assign rsp_wst = '{rd_data: rsp_data_q, rd_data_valid: rsp_valid_q};

    // decode never drives both strobes
    a_pio_one_op: assert property (
        @(posedge clk) disable iff (reset) !(pio_req.read && pio_req.write));

    // register file answers exactly two cycles after each read
    a_pio_rsp_align: assert property (
        @(posedge clk) disable iff (reset) (pio_rsp.ack || pio_rsp.nack) == rd_en_d2);

endmodule

// File: glb_tile_cfg_regs.sv
`timescale 1ns/1ns
`include "glb_cfg_settings.svh"

module glb_tile_cfg_regs
    import glb_cfg_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  pio_req_t pio_req,
    output pio_rsp_t pio_rsp
);

    // index bits that select an implemented register
    localparam int IDX_WIDTH = $clog2(`GLB_NUM_REGS);

    cfg_data_t            cfg_reg [`GLB_NUM_REGS];
    logic                 wr_hit;
    logic                 rd_hit;
    logic [IDX_WIDTH-1:0] wr_idx;
    logic [IDX_WIDTH-1:0] rd_idx;
    // read stage 1
    logic                 rd_s1;
    logic                 hit_s1;
    cfg_data_t            data_s1;
    // read stage 2 drives the bus
    logic                 ack_q;
    logic                 nack_q;
    cfg_data_t            data_q;

    // only the low registers exist
    assign wr_hit = pio_req.write && (pio_req.address < `GLB_NUM_REGS);
    assign rd_hit = pio_req.read && (pio_req.address < `GLB_NUM_REGS);
    assign wr_idx = pio_req.address[IDX_WIDTH-1:0];
    assign rd_idx = pio_req.address[IDX_WIDTH-1:0];

    // writes land at the next edge and misses are dropped
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `GLB_NUM_REGS; i++) begin
                cfg_reg[i] <= '0;
            end
        end else if (wr_hit) begin
            cfg_reg[wr_idx] <= pio_req.write_data;
        end
    end

    // strobes of both read stages
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_s1  <= 1'b0;
            hit_s1 <= 1'b0;
            ack_q  <= 1'b0;
            nack_q <= 1'b0;
        end else begin
            rd_s1  <= pio_req.read;
            hit_s1 <= rd_hit;
            ack_q  <= rd_s1 && hit_s1;
            nack_q <= rd_s1 && !hit_s1;
        end
    end

    // read data path
    always_ff @(posedge clk) begin
        data_s1 <= cfg_reg[rd_idx];
        // unimplemented address reads as zero
        data_q  <= hit_s1 ? data_s1 : '0;
    end

    assign pio_rsp = '{read_data: data_q, ack: ack_q, nack: nack_q};

    // ack and nack exclude each other
    a_ack_nack_excl: assert property (
        @(posedge clk) disable iff (reset) !(pio_rsp.ack && pio_rsp.nack));

endmodule

// File: glb_cfg_chain.sv
`timescale 1ns/1ns
`include "glb_cfg_settings.svh"

module glb_cfg_chain
    import glb_cfg_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  cfg_wr_req_t cfg_wr,
    input  cfg_rd_req_t cfg_rd,
    output cfg_rd_rsp_t cfg_rsp
);

    // index k is the west side of tile k
    cfg_wr_req_t wr_chain  [`GLB_NUM_TILES];
    cfg_rd_req_t rd_chain  [`GLB_NUM_TILES];
    cfg_rd_rsp_t rsp_chain [`GLB_NUM_TILES];
    // per-tile register bus
    pio_req_t    pio_req   [`GLB_NUM_TILES];
    pio_rsp_t    pio_rsp   [`GLB_NUM_TILES];

    // host attaches at the west end of tile 0
    assign wr_chain[0] = cfg_wr;
    assign rd_chain[0] = cfg_rd;
    assign cfg_rsp     = rsp_chain[0];

    for (genvar i = 0; i < `GLB_NUM_TILES; i++) begin : g_tile
        if (i < `GLB_NUM_TILES - 1) begin : g_mid
            glb_tile_cfg_ctrl #(
                .TILE_ID(tile_id_t'(i))
            ) i_ctrl (
                .clk    (clk),
                .reset  (reset),
                .wr_wst (wr_chain[i]),
                .rd_wst (rd_chain[i]),
                .rsp_wst(rsp_chain[i]),
                .wr_est (wr_chain[i+1]),
                .rd_est (rd_chain[i+1]),
                .rsp_est(rsp_chain[i+1]),
                .pio_req(pio_req[i]),
                .pio_rsp(pio_rsp[i])
            );
        end else begin : g_last
            // east end: requests fall off, nothing comes back
            glb_tile_cfg_ctrl #(
                .TILE_ID(tile_id_t'(i))
            ) i_ctrl (
                .clk    (clk),
                .reset  (reset),
                .wr_wst (wr_chain[i]),
                .rd_wst (rd_chain[i]),
                .rsp_wst(rsp_chain[i]),
                .wr_est (),
                .rd_est (),
                .rsp_est('0),
                .pio_req(pio_req[i]),
                .pio_rsp(pio_rsp[i])
            );
        end

        glb_tile_cfg_regs i_regs (
            .clk    (clk),
            .reset  (reset),
            .pio_req(pio_req[i]),
            .pio_rsp(pio_rsp[i])
        );
    end

endmodule

// File: tb_glb_cfg_chain.sv
`timescale 1ns/1ns
`include "glb_cfg_settings.svh"

module tb_glb_cfg_chain
    import glb_cfg_pkg::*;
();

    logic        clk;
    logic        reset;
    cfg_wr_req_t cfg_wr;
    cfg_rd_req_t cfg_rd;
    cfg_rd_rsp_t cfg_rsp;

    // expected register contents per tile
    cfg_data_t   model [`GLB_NUM_TILES][`GLB_NUM_REGS];
    logic [31:0] lfsr_state;
    int          test_errs;
    int          tests_passed;
    int          tests_failed;

    glb_cfg_chain i_dut (
        .clk    (clk),
        .reset  (reset),
        .cfg_wr (cfg_wr),
        .cfg_rd (cfg_rd),
        .cfg_rsp(cfg_rsp)
    );

    always #10 clk = ~clk;

    // galois lfsr with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit
    task automatic take_bits(input int nbits, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, exp);
            test_errs++;
        end
    endtask

    task automatic report_fail(input string what);
        $display("ERROR: %s", what);
        test_errs++;
    endtask

    // inputs move 2 ns after the rising edge
    task automatic tick;
        @(posedge clk);
        #2;
    endtask

    // byte address with offset, register and tile from the lsb up
    function automatic cfg_addr_t make_addr(input int tile, input int reg_a, input int offset);
        return cfg_addr_t'((tile << (`GLB_BYTE_OFFSET + `GLB_REG_ADDR_WIDTH))
                           | (reg_a << `GLB_BYTE_OFFSET)
                           | (offset & ((1 << `GLB_BYTE_OFFSET) - 1)));
    endfunction

    // model follows only a write that can land
    task automatic do_write(input int tile, input int reg_a, input cfg_data_t data,
                            input logic clk_en);
        tick;
        cfg_wr.wr_en     = 1'b1;
        cfg_wr.wr_clk_en = clk_en;
        cfg_wr.wr_addr   = make_addr(tile, reg_a, 0);
        cfg_wr.wr_data   = data;
        tick;
        cfg_wr.wr_en     = 1'b0;
        cfg_wr.wr_clk_en = 1'b1;
        // tile 0 decodes its own writes whatever clk_en says
        if ((clk_en || tile == 0) && tile < `GLB_NUM_TILES && reg_a < `GLB_NUM_REGS) begin
            model[tile][reg_a] = data;
        end
    endtask

    // leaves us in cycle 1 counted from the read strobe
    task automatic issue_read(input int tile, input int reg_a, input int offset);
        tick;
        cfg_rd.rd_en   = 1'b1;
        cfg_rd.rd_addr = make_addr(tile, reg_a, offset);
        tick;
        cfg_rd.rd_en   = 1'b0;
    endtask

    // samples at the falling edge and returns the strobe cycle in lat
    task automatic wait_valid(input int limit, output int lat, output bit got,
                              output cfg_data_t data);
        got  = 1'b0;
        data = '0;
        lat  = 1;
        while (!got && lat <= limit) begin
            @(negedge clk);
            if (cfg_rsp.rd_data_valid) begin
                got  = 1'b1;
                data = cfg_rsp.rd_data;
            end else begin
                lat++;
            end
        end
    endtask

    task automatic expect_silence(input int cycles, input string what);
        bit seen;
        seen = 1'b0;
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (cfg_rsp.rd_data_valid) begin
                seen = 1'b1;
            end
        end
        if (seen) begin
            report_fail($sformatf("a read response appeared after %s", what));
        end
    endtask

    // read, then check data and the 2k+4 return latency
    task automatic read_check(input int tile, input int reg_a, input int offset,
                              input cfg_data_t exp);
        int        lat;
        bit        got;
        cfg_data_t data;
        issue_read(tile, reg_a, offset);
        wait_valid(2 * `GLB_NUM_TILES + 8, lat, got, data);
        if (!got) begin
            report_fail($sformatf("no read response from tile %0d register %0d",
                                  tile, reg_a));
        end else begin
            check_value($sformatf("cfg_rsp.rd_data[t%0d r%0d]", tile, reg_a), data, exp);
            check_value($sformatf("latency[t%0d]", tile), lat, 2 * tile + 4);
        end
    endtask

    task automatic read_tile(input int tile);
        logic [31:0] offset;
        for (int r = 0; r < `GLB_NUM_REGS; r++) begin
            take_bits(`GLB_BYTE_OFFSET, offset);
            read_check(tile, r, offset, model[tile][r]);
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errs == 0) begin
            tests_passed++;
            $display("test %-12s ok", name);
        end else begin
            tests_failed++;
            $display("test %-12s FAILED with %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    task automatic test_reset;
        @(negedge clk);
        check_value("cfg_rsp.rd_data_valid", 32'(cfg_rsp.rd_data_valid), 32'h0);
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            for (int r = 0; r < `GLB_NUM_REGS; r++) begin
                read_check(t, r, 0, '0);
            end
        end
        finish_test("reset");
    endtask

    task automatic test_round_trip;
        logic [31:0] r;
        logic [31:0] d;
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            for (int n = 0; n < 4; n++) begin
                take_bits(4, r);
                take_bits(32, d);
                do_write(t, r, d, 1'b1);
            end
        end
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            read_tile(t);
        end
        finish_test("round_trip");
    endtask

    // same register gets a distinct value per tile
    task automatic test_isolation;
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            do_write(t, 5, {8'hc0, 8'(t), 16'hbeef}, 1'b1);
        end
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            read_check(t, 5, 0, {8'hc0, 8'(t), 16'hbeef});
        end
        finish_test("isolation");
    endtask

    task automatic test_unimpl;
        logic [31:0] r;
        logic [31:0] d;
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            take_bits(5, r);
            take_bits(32, d);
            read_check(t, `GLB_NUM_REGS + r, 0, '0);
            // low bits alias an implemented index
            do_write(t, `GLB_NUM_REGS + r, d, 1'b1);
            read_tile(t);
        end
        finish_test("unimpl");
    endtask

    task automatic test_priority;
        logic [31:0] d;
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            take_bits(32, d);
            tick;
            cfg_wr.wr_en   = 1'b1;
            cfg_wr.wr_addr = make_addr(t, 9, 0);
            cfg_wr.wr_data = d;
            cfg_rd.rd_en   = 1'b1;
            cfg_rd.rd_addr = make_addr(t, 9, 0);
            tick;
            cfg_wr.wr_en   = 1'b0;
            cfg_rd.rd_en   = 1'b0;
            model[t][9]    = d;
            expect_silence(2 * t + 8, $sformatf("a same-cycle write and read to tile %0d", t));
            read_check(t, 9, 0, model[t][9]);
        end
        // gated write must not reach tile 1
        take_bits(32, d);
        do_write(1, 3, d, 1'b0);
        read_check(1, 3, 0, model[1][3]);
        finish_test("priority");
    endtask

    task automatic test_missing;
        logic [31:0] id;
        take_bits(3, id);
        issue_read(`GLB_NUM_TILES + id, 2, 0);
        expect_silence(2 * `GLB_NUM_TILES + 8, "a read to a missing tile");
        read_check(2, 2, 0, model[2][2]);
        finish_test("missing");
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        cfg_wr       = '0;
        cfg_rd       = '0;
        // clock enables stay high unless a test gates them
        cfg_wr.wr_clk_en = 1'b1;
        cfg_rd.rd_clk_en = 1'b1;
        lfsr_state   = 32'h7206_97a1;
        test_errs    = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            for (int r = 0; r < `GLB_NUM_REGS; r++) begin
                model[t][r] = '0;
            end
        end
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;

        test_reset();
        test_round_trip();
        test_isolation();
        test_unimpl();
        test_priority();
        test_missing();

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+.
glb_cfg_pkg.sv
glb_tile_cfg_ctrl.sv
glb_tile_cfg_regs.sv
glb_cfg_chain.sv
tb_glb_cfg_chain.sv

// File: Makefile
SIM   := verilator
FLAGS := --timing --assert
TOP   := tb_glb_cfg_chain
FLIST := flist.f
OBJ   := obj_dir
LOG   := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) --lint-only $(FLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	rm -f $(LOG)
	$(SIM) --binary $(FLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
